// File: flist.f
+incdir+include
design/gat_pkg.sv
design/conv_mem_if.sv
design/bram.sv
design/dot_product_engine.sv
design/memory_controller.sv
design/gat_mem_top.sv
test/gat_mem_asserts.sv
test/tb_gat_mem.sv

// File: test/tb_gat_mem.sv
// Directed testbench for gat_mem_top that loads H and weights, runs both layers and checks results
`include "gat_params.svh"

module tb_gat_mem
  import gat_pkg::*;
();

  timeunit 1ns;
  timeprecision 1ps;

  localparam int RUN_TIMEOUT = 1000;

  logic    clk;
  logic    rst_n;
  logic    gat_layer;
  logic    start;
  logic    done;
  data_t   h_din;
  logic    h_we;
  h_addr_t h_addr;
  data_t   w_din;
  logic    w_we;
  w_addr_t w_addr;
  node_t   feat_raddr;
  acc_t    feat_rdata;

  // Reference copies of what was loaded
  data_t       h_model [`GAT_H_DEPTH];
  data_t       w_model [`GAT_W_DEPTH];
  logic [15:0] lfsr = 16'd41;

  gat_mem_top dut0 (.*);

  always #10 clk = ~clk;

  // ==============================
  // Helpers
  // ==============================
  task automatic next_cycle();
    @(posedge clk);
    #2;
  endtask

  task automatic stop_run(input string line);
    $display("%s", line);
    $display("Test FAILED");
    $fatal(1);
  endtask

  // Protocol assertions bound into the memory controller
  always @(dut0.u_mem_ctrl.u_asserts.fail_count) begin
    if (dut0.u_mem_ctrl.u_asserts.fail_count != 0) begin
      stop_run("A protocol assertion on the memory controller failed");
    end
  end

  // Taps 16, 14, 13, 11
  function automatic logic [15:0] lfsr_next(input logic [15:0] s);
    return {s[14:0], s[15] ^ s[13] ^ s[12] ^ s[10]};
  endfunction

  task automatic random_data(output data_t val);
    val = '0;
    for (int i = 0; i < `GAT_DATA_W; i++) begin
      lfsr = lfsr_next(lfsr);
      val  = {val[`GAT_DATA_W-2:0], lfsr[0]};
    end
  endtask

  // Sum over k of h[n*FEAT_IN+k] * w[base+k]
  function automatic acc_t expected_feat(input int node, input logic layer);
    acc_t sum;
    int   base;
    sum  = '0;
    base = layer ? `GAT_FEAT_IN : 0;
    for (int k = 0; k < `GAT_FEAT_IN; k++) begin
      sum = sum + acc_t'(h_model[node * `GAT_FEAT_IN + k]) * acc_t'(w_model[base + k]);
    end
    return sum;
  endfunction

  task automatic check_acc(input acc_t got, input acc_t exp, input string what);
    if (got !== exp) begin
      stop_run($sformatf("CHECK FAILED at %0t ns: %s got %0d expected %0d",
                         $time, what, got, exp));
    end
  endtask

  task automatic check_bit(input logic got, input logic exp, input string what);
    if (got !== exp) begin
      stop_run($sformatf("CHECK FAILED at %0t ns: %s got %b expected %b",
                         $time, what, got, exp));
    end
  endtask

  // ==============================
  // Host side tasks
  // ==============================
  task automatic load_h(input logic all_max);
    data_t v;
    for (int a = 0; a < `GAT_H_DEPTH; a++) begin
      if (all_max) v = '1;
      else random_data(v);
      h_model[a] = v;
      h_addr     = h_addr_t'(a);
      h_din      = v;
      h_we       = 1'b1;
      next_cycle();
    end
    h_we = 1'b0;
  endtask

  task automatic load_w(input logic all_max);
    data_t v;
    for (int a = 0; a < `GAT_W_DEPTH; a++) begin
      if (all_max) v = '1;
      else random_data(v);
      w_model[a] = v;
      w_addr     = w_addr_t'(a);
      w_din      = v;
      w_we       = 1'b1;
      next_cycle();
    end
    w_we = 1'b0;
  endtask

  task automatic run_layer(input logic layer, input logic extra_start);
    int cycles;
    gat_layer = layer;
    start     = 1'b1;
    next_cycle();
    start = 1'b0;
    if (extra_start) begin
      repeat (3) next_cycle();
      start = 1'b1;
      next_cycle();
      start = 1'b0;
    end
    cycles = 0;
    while (done !== 1'b1) begin
      if (cycles == RUN_TIMEOUT) begin
        stop_run($sformatf("Timeout: no done pulse within %0d cycles of start", RUN_TIMEOUT));
      end
      next_cycle();
      cycles++;
    end
    // An ignored start must not lead to a second done
    if (extra_start) begin
      repeat (100) begin
        next_cycle();
        check_bit(done, 1'b0, "done after ignored start");
      end
    end
  endtask

  task automatic read_feat(input node_t n, output acc_t val);
    feat_raddr = n;
    next_cycle();
    val = feat_rdata;
  endtask

  task automatic check_layer(input logic layer);
    acc_t got;
    for (int n = 0; n < `GAT_NUM_NODES; n++) begin
      read_feat(node_t'(n), got);
      check_acc(got, expected_feat(n, layer),
                $sformatf("layer %0d node %0d", layer + 1, n));
    end
  endtask

  task automatic check_reset_state();
    check_acc(feat_rdata, '0, "feat_rdata after reset");
    repeat (10) begin
      check_bit(done, 1'b0, "done after reset");
      next_cycle();
    end
  endtask

  task automatic check_max_values();
    acc_t got;
    load_h(1'b1);
    load_w(1'b1);
    run_layer(1'b0, 1'b0);
    for (int n = 0; n < `GAT_NUM_NODES; n++) begin
      read_feat(node_t'(n), got);
      check_acc(got, acc_t'(`GAT_FEAT_IN * 255 * 255), $sformatf("max data node %0d", n));
    end
  endtask

  // ==============================
  // Main sequence
  // ==============================
  initial begin
    clk        = 1'b0;
    rst_n      = 1'b0;
    gat_layer  = 1'b0;
    start      = 1'b0;
    h_din      = '0;
    h_we       = 1'b0;
    h_addr     = '0;
    w_din      = '0;
    w_we       = 1'b0;
    w_addr     = '0;
    feat_raddr = '0;
    repeat (8) @(posedge clk);
    #2;
    rst_n = 1'b1;

    check_reset_state();
    load_h(1'b0);
    load_w(1'b0);
    run_layer(1'b0, 1'b0);
    check_layer(1'b0);
    // Same H with the second weight vector
    run_layer(1'b1, 1'b0);
    check_layer(1'b1);
    load_h(1'b0);
    run_layer(1'b0, 1'b0);
    check_layer(1'b0);
    run_layer(1'b1, 1'b1);
    check_layer(1'b1);
    check_max_values();

    $display("Test OK");
    $finish;
  end

endmodule

// File: test/gat_mem_asserts.sv
// Concurrent protocol checks that are bound into every memory_controller instance
module gat_mem_asserts (
  input logic clk,
  input logic rst_n,
  input logic start,
  input logic done,
  input logic gat_layer,
  input logic feat_we
);

  timeunit 1ns;
  timeprecision 1ps;

  // High from the cycle after start until the cycle after done
  logic busy;
  // Follows rst_n one clock late so the X before the first reset is skipped
  logic in_reset = 1'b0;
  // Count of assertion failures
  int   fail_count = 0;

  always_ff @(posedge clk) begin
    in_reset <= !rst_n;
    if (!rst_n) begin
      busy <= 1'b0;
    end else if (done) begin
      busy <= 1'b0;
    end else if (start) begin
      busy <= 1'b1;
    end
  end

  done_single_pulse: assert property (@(posedge clk) disable iff (!rst_n) done |=> !done)
    else begin
      fail_count++;
      $error("done stayed high for more than one cycle");
    end

  no_write_in_reset: assert property (@(posedge clk) (in_reset && !rst_n) |-> !feat_we)
    else begin
      fail_count++;
      $error("feat_we high while in reset");
    end

  layer_stable_in_run: assert property (@(posedge clk) disable iff (!rst_n)
    busy |-> $stable(gat_layer))
    else begin
      fail_count++;
      $error("gat_layer changed between start and done");
    end

endmodule

bind memory_controller gat_mem_asserts u_asserts (
  .clk       (clk),
  .rst_n     (rst_n),
  .start     (start),
  .done      (done),
  .gat_layer (gat_layer),
  .feat_we   (feat_we)
);

// File: design/gat_mem_top.sv
// Top level of the GAT memory block, joins the controller with the conv1 and conv2 engines
`include "gat_params.svh"

module gat_mem_top
  import gat_pkg::*;
(
  input  logic    clk,
  input  logic    rst_n,

  // ==============================
  // Control
  // ==============================
  input  logic    gat_layer,
  input  logic    start,
  output logic    done,

  // ==============================
  // Host load
  // ==============================
  input  data_t   h_din,
  input  logic    h_we,
  input  h_addr_t h_addr,
  input  data_t   w_din,
  input  logic    w_we,
  input  w_addr_t w_addr,

  // Feature readback, one clock latency
  input  node_t   feat_raddr,
  output acc_t    feat_rdata
);

  logic conv1_start;
  logic conv2_start;
  logic conv1_done;
  logic conv2_done;

  conv_mem_if conv1_mem ();
  conv_mem_if conv2_mem ();

  memory_controller u_mem_ctrl (
    .clk         (clk),
    .rst_n       (rst_n),
    .gat_layer   (gat_layer),
    .start       (start),
    .done        (done),
    .h_din       (h_din),
    .h_we        (h_we),
    .h_addr      (h_addr),
    .w_din       (w_din),
    .w_we        (w_we),
    .w_addr      (w_addr),
    .feat_raddr  (feat_raddr),
    .feat_rdata  (feat_rdata),
    .conv1       (conv1_mem.mem),
    .conv2       (conv2_mem.mem),
    .conv1_start (conv1_start),
    .conv2_start (conv2_start),
    .conv1_done  (conv1_done),
    .conv2_done  (conv2_done)
  );

  // Layer 1 uses the first weight vector
  dot_product_engine #(
    .WGT_BASE (0)
  ) u_conv1 (
    .clk   (clk),
    .rst_n (rst_n),
    .start (conv1_start),
    .done  (conv1_done),
    .mem   (conv1_mem.engine)
  );

  // Layer 2 weights start after FEAT_IN entries
  dot_product_engine #(
    .WGT_BASE (`GAT_FEAT_IN)
  ) u_conv2 (
    .clk   (clk),
    .rst_n (rst_n),
    .start (conv2_start),
    .done  (conv2_done),
    .mem   (conv2_mem.engine)
  );

endmodule

// File: design/memory_controller.sv
// Owns the H, weight and feature RAMs and hands them to the engine picked by gat_layer
`include "gat_params.svh"

module memory_controller
  import gat_pkg::*;
(
  input  logic     clk,
  input  logic     rst_n,
  input  logic     gat_layer,
  input  logic     start,
  output logic     done,

  // ==============================
  // Host load and readback
  // ==============================
  input  data_t    h_din,
  input  logic     h_we,
  input  h_addr_t  h_addr,
  input  data_t    w_din,
  input  logic     w_we,
  input  w_addr_t  w_addr,
  input  node_t    feat_raddr,
  output acc_t     feat_rdata,

  // ==============================
  // Engines
  // ==============================
  conv_mem_if.mem  conv1,
  conv_mem_if.mem  conv2,
  output logic     conv1_start,
  output logic     conv2_start,
  input  logic     conv1_done,
  input  logic     conv2_done
);

  h_addr_t h_raddr;
  w_addr_t w_raddr;
  data_t   h_rdata;
  data_t   w_rdata;

  logic    feat_we;
  node_t   feat_waddr;
  acc_t    feat_din;

  // Layer select, low is conv1 and high is conv2
  assign h_raddr    = (gat_layer == 1'b0) ? conv1.h_addr    : conv2.h_addr;
  assign w_raddr    = (gat_layer == 1'b0) ? conv1.w_addr    : conv2.w_addr;
  assign feat_we    = (gat_layer == 1'b0) ? conv1.feat_we   : conv2.feat_we;
  assign feat_waddr = (gat_layer == 1'b0) ? conv1.feat_addr : conv2.feat_addr;
  assign feat_din   = (gat_layer == 1'b0) ? conv1.feat_din  : conv2.feat_din;

  assign conv1_start = start & ~gat_layer;
  assign conv2_start = start &  gat_layer;
  assign done        = (gat_layer == 1'b0) ? conv1_done : conv2_done;

  // Both engines see the same RAM outputs
  assign conv1.h_dout = h_rdata;
  assign conv1.w_dout = w_rdata;
  assign conv2.h_dout = h_rdata;
  assign conv2.w_dout = w_rdata;

  // ==============================
  // Memories
  // ==============================
  bram #(
    .DATA_WIDTH (`GAT_DATA_W),
    .DEPTH      (`GAT_H_DEPTH)
  ) u_h_bram (
    .clk   (clk),
    .rst_n (rst_n),
    .din   (h_din),
    .addra (h_addr),
    .wea   (h_we),
    .addrb (h_raddr),
    .dout  (h_rdata)
  );

  bram #(
    .DATA_WIDTH (`GAT_DATA_W),
    .DEPTH      (`GAT_W_DEPTH)
  ) u_wgt_bram (
    .clk   (clk),
    .rst_n (rst_n),
    .din   (w_din),
    .addra (w_addr),
    .wea   (w_we),
    .addrb (w_raddr),
    .dout  (w_rdata)
  );

  // Engine writes on port A, host reads back on port B
  bram #(
    .DATA_WIDTH (`GAT_ACC_W),
    .DEPTH      (`GAT_FEAT_DEPTH)
  ) u_feat_bram (
    .clk   (clk),
    .rst_n (rst_n),
    .din   (feat_din),
    .addra (feat_waddr),
    .wea   (feat_we),
    .addrb (feat_raddr),
    .dout  (feat_rdata)
  );

endmodule

// File: design/dot_product_engine.sv
// Per-node dot product of an H row with one layer's weight vector, written to feature RAM
`include "gat_params.svh"

module dot_product_engine
  import gat_pkg::*;
#(
  // First weight address of this layer's vector
  parameter int WGT_BASE = 0
) (
  input  logic           clk,
  input  logic           rst_n,
  input  logic           start,
  output logic           done,
  conv_mem_if.engine     mem
);

  localparam int FEAT_IDX_W = $clog2(`GAT_FEAT_IN);

  localparam logic [FEAT_IDX_W-1:0] LAST_FEAT = FEAT_IDX_W'(`GAT_FEAT_IN - 1);
  localparam node_t                 LAST_NODE = node_t'(`GAT_NUM_NODES - 1);

  conv_state_t           state;
  conv_state_t           next_state;
  node_t                 node_cnt;
  logic [FEAT_IDX_W-1:0] feat_cnt;
  // Read data from the previous cycle is on h_dout / w_dout
  logic                  rd_vld;
  acc_t                  acc;
  acc_t                  prod;

  // ==============================
  // Next state
  // ==============================
  always_comb begin
    next_state = state;
    case (state)
      IDLE:  if (start) next_state = READ;
      READ:  if (feat_cnt == LAST_FEAT) next_state = LAST;
      // One spare cycle to catch the final read
      LAST:  next_state = WRITE;
      WRITE: next_state = (node_cnt == LAST_NODE) ? IDLE : READ;
      default: next_state = IDLE;
    endcase
  end

  // ==============================
  // State, counters and done
  // ==============================
  always_ff @(posedge clk) begin
    if (!rst_n) begin
      state    <= IDLE;
      node_cnt <= '0;
      feat_cnt <= '0;
      rd_vld   <= 1'b0;
      done     <= 1'b0;
    end else begin
      state  <= next_state;
      rd_vld <= (state == READ);
      // Pulse one cycle after the last node is written
      done   <= (state == WRITE) && (node_cnt == LAST_NODE);
      case (state)
        IDLE: begin
          node_cnt <= '0;
          feat_cnt <= '0;
        end
        READ: begin
          feat_cnt <= (feat_cnt == LAST_FEAT) ? '0 : feat_cnt + 1'b1;
        end
        WRITE: begin
          node_cnt <= (node_cnt == LAST_NODE) ? '0 : node_cnt + 1'b1;
        end
        default: ;
      endcase
    end
  end

  // ==============================
  // Multiply and accumulate
  // ==============================
  assign prod = acc_t'(mem.h_dout) * acc_t'(mem.w_dout);

  // Cleared between nodes, so the next row starts from zero
  always_ff @(posedge clk) begin
    if (state == IDLE || state == WRITE) begin
      acc <= '0;
    end else if (rd_vld) begin
      acc <= acc + prod;
    end
  end

  // ==============================
  // Memory ports
  // ==============================
  assign mem.h_addr    = h_addr_t'(node_cnt) * h_addr_t'(`GAT_FEAT_IN) + h_addr_t'(feat_cnt);
  assign mem.w_addr    = w_addr_t'(WGT_BASE) + w_addr_t'(feat_cnt);

  assign mem.feat_we   = (state == WRITE);
  assign mem.feat_addr = node_cnt;
  assign mem.feat_din  = acc;

endmodule

// File: design/bram.sv
// Simple dual-port RAM, write on port A and registered read on port B
`include "gat_params.svh"

module bram #(
  parameter int DATA_WIDTH = `GAT_DATA_W,
  parameter int DEPTH      = `GAT_H_DEPTH,
  localparam int ADDR_W    = $clog2(DEPTH)
) (
  input  logic                  clk,
  input  logic                  rst_n,
  input  logic [DATA_WIDTH-1:0] din,
  input  logic [ADDR_W-1:0]     addra,
  input  logic                  wea,
  input  logic [ADDR_W-1:0]     addrb,
  output logic [DATA_WIDTH-1:0] dout
);

  logic [DATA_WIDTH-1:0] mem [DEPTH];

  // ==============================
  // Port A write
  // ==============================
  always_ff @(posedge clk) begin
    if (wea) begin
      mem[addra] <= din;
    end
  end

  // ==============================
  // Port B read, one clock latency
  // ==============================
  always_ff @(posedge clk) begin
    if (!rst_n) begin
      dout <= '0;
    end else begin
      dout <= mem[addrb];
    end
  end

endmodule

// File: design/conv_mem_if.sv
// Memory port bundle between one dot-product engine and the memory controller
`include "gat_params.svh"

interface conv_mem_if
  import gat_pkg::*;
();

  // Read side, address out and data back one clock later
  h_addr_t h_addr;
  w_addr_t w_addr;
  data_t   h_dout;
  data_t   w_dout;

  // Feature write side
  logic    feat_we;
  node_t   feat_addr;
  acc_t    feat_din;

  modport engine (
    output h_addr, w_addr,
    input  h_dout, w_dout,
    output feat_we, feat_addr, feat_din
  );

  modport mem (
    input  h_addr, w_addr,
    output h_dout, w_dout,
    input  feat_we, feat_addr, feat_din
  );

endinterface

// File: design/gat_pkg.sv
// Shared types for the GAT memory block, imported by the controller, engines and top
`include "gat_params.svh"

package gat_pkg;

  // ==============================
  // Data types
  // ==============================
  typedef logic [`GAT_DATA_W-1:0] data_t;
  typedef logic [`GAT_ACC_W-1:0]  acc_t;

  // ==============================
  // Address types
  // ==============================
  typedef logic [$clog2(`GAT_H_DEPTH)-1:0]    h_addr_t;
  typedef logic [$clog2(`GAT_W_DEPTH)-1:0]    w_addr_t;
  // Node index doubles as feature RAM address
  typedef logic [$clog2(`GAT_FEAT_DEPTH)-1:0] node_t;

  // Dot-product engine states
  typedef enum logic [1:0] {
    IDLE,
    READ,
    LAST,
    WRITE
  } conv_state_t;

endpackage

// File: include/gat_params.svh
// Size and depth macros for the GAT memory block, included by every RTL file
`ifndef GAT_PARAMS_SVH
`define GAT_PARAMS_SVH

// ==============================
// Data widths
// ==============================
// H value and weight width
`define GAT_DATA_W      8
// Dot-product result width
`define GAT_ACC_W       20

// ==============================
// Graph sizes and RAM depths
// ==============================
`define GAT_FEAT_IN     4
`define GAT_NUM_NODES   8
// Nodes times FEAT_IN
`define GAT_H_DEPTH     32
// Two weight vectors of FEAT_IN
`define GAT_W_DEPTH     8
// One result word per node
`define GAT_FEAT_DEPTH  8

`endif
